//--- hb_stimulus.txt
# columns: T id hold name | E n values | R n value | X n | S value n | P first second n
# N cycles is an output-free window, D drains and ends the test
T 1 0 first_pair
E 1 0
S 0 1
N 50
S 0 1
D
# impulse at a kept position, outputs follow the coefficient table
T 2 0 impulse
E 22 0 -1 1 -2 3 -4 6 -9 13 -17 23 -30 39 -50 63 -79 99 -121 148 -180 218 -262
E 22 315 -379 457 -553 676 -839 1068 -1418 2034 -3445 10420 10420 -3445 2034 -1418 1068 -839 676 -553 457 -379 315
E 22 -262 218 -180 148 -121 99 -79 63 -50 39 -30 23 -17 13 -9 6 -4 3 -2 1 -1 0
P 0 16384 1
P 0 0 65
D
# large samples only at discarded positions
T 3 0 decimation
R 20 0
P 32767 0 10
P -32768 0 10
D
# dc gain is twice the coefficient sum
T 4 0 dc
X 65
R 10 30001
P 30000 30000 75
D
# sink holds its credits until the DUT stalls
T 5 1 backpressure
R 10 30001
P 30000 30000 10
D
T 6 0 credits
X 30
P 1234 -4321 30
D

//--- sources.f
halfband_pkg.sv
flow_pkg.sv
mac_ctrl_if.sv
credit_fifo.sv
tap_delay_line.sv
mac_unit.sv
decim_control.sv
hb_decim_top.sv
tb_hb_decim.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_hb_decim
FILELIST  = sources.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- tb_hb_decim.sv
`timescale 1ns/10ps
`default_nettype none

module tb_hb_decim import halfband_pkg::*, flow_pkg::*; ();

    logic    clk;
    logic    reset;
    logic    in_valid;
    sample_t in_data;
    logic    in_credit;
    logic    out_valid;
    result_t out_data;
    logic    out_credit = 1'b0;

    integer  seed;
    int      snd_credits    = IN_CREDITS;      // sender's view of input FIFO space
    int      samples_sent   = 0;
    int      credit_pulses  = 0;
    int      owed           = 0;               // credits the sink still has to return
    logic    hold_credits   = 1'b0;
    int      test_outputs   = 0;
    int      window_outputs = 0;
    int      errors         = 0;
    int      cycles         = 0;
    int      limit_cycles   = 2000;            // grows by 40 cycles per sample sent
    int      exp_q [$];
    bit      care_q [$];                       // 0 means any value is accepted

    hb_decim_top dut0 (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_data(in_data), .in_credit(in_credit),
        .out_valid(out_valid), .out_data(out_data), .out_credit(out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    // credits back to the DUT one cycle after each result
    always @(posedge clk) begin
        #1;
        if (!hold_credits && owed > 0) begin
            out_credit = 1'b1;
            owed--;
        end else begin
            out_credit = 1'b0;
        end
    end

    always @(negedge clk) begin : output_monitor
        int want;
        bit care;
        if (in_credit) begin
            credit_pulses++;
            if (snd_credits >= IN_CREDITS) begin
                $display("in_credit pulse with no sample outstanding at %0t", $time);
                errors++;
            end else begin
                snd_credits++;
            end
        end
        if (out_valid) begin
            test_outputs++;
            window_outputs++;
            owed++;
            if (exp_q.size() == 0) begin
                $display("output %0d arrived when none was expected at %0t", out_data, $time);
                errors++;
            end else begin
                want = exp_q.pop_front();
                care = care_q.pop_front();
                if (care && int'(out_data) != want) begin
                    $display("ERR %0t: output is %0d, expected %0d", $time, out_data, want);
                    errors++;
                end
            end
        end
    end

    initial begin : watchdog
        while (cycles <= limit_cycles) begin
            @(posedge clk);
        end
        $display("timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("Some tests failed");
        $finish;
    end

    // called and left at 1 ns after a rising edge
    task automatic send_sample(input int value);
        int gap;
        gap = int'($unsigned($random(seed)) % 3);
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        while (snd_credits == 0) begin
            @(posedge clk);
            #1;
        end
        in_valid = 1'b1;
        in_data  = sample_t'(value);
        snd_credits--;
        samples_sent++;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic send_pairs(input int first, input int second, input int n);
        repeat (n) begin
            send_sample(first);                 // dropped by the decimator
            send_sample(second);
        end
    endtask

    task automatic idle_window(input int n);
        window_outputs = 0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
        if (window_outputs != 0) begin
            $display("ERR %0t: %0d outputs in idle window, expected 0", $time, window_outputs);
            errors++;
        end
    endtask

    task automatic release_after_stall();
        while (test_outputs < OUT_CREDITS) begin
            @(posedge clk);
            #1;
        end
        repeat (200) begin                       // several sweeps, DUT must stall
            @(posedge clk);
            #1;
        end
        if (test_outputs != OUT_CREDITS) begin
            $display("ERR %0t: %0d outputs with credits held, expected %0d",
                     $time, test_outputs, OUT_CREDITS);
            errors++;
        end
        hold_credits = 1'b0;
    endtask

    task automatic drain_and_check(input int exp_count);
        while (exp_q.size() != 0 || snd_credits != IN_CREDITS) begin
            @(posedge clk);
            #1;
        end
        repeat (40) begin                        // room for a stray result
            @(posedge clk);
            #1;
        end
        if (test_outputs != exp_count) begin
            $display("ERR %0t: %0d outputs, expected %0d", $time, test_outputs, exp_count);
            errors++;
        end
        if (credit_pulses != samples_sent) begin
            $display("ERR %0t: %0d in_credit pulses for %0d samples",
                     $time, credit_pulses, samples_sent);
            errors++;
        end
    endtask

    initial begin : main
        int fd;
        int v;
        int n;
        int a;
        int b;
        int id;
        int hold;
        int start_err;
        int exp_count;
        int tests_run;
        int tests_failed;
        logic [8*16-1:0]  cmd;
        logic [8*16-1:0]  name;
        logic [8*128-1:0] rest;
        seed         = 32'hec46;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_data      = '0;
        tests_run    = 1;
        tests_failed = 0;
        exp_count    = 0;
        id           = 0;
        name         = "";
        start_err    = errors;
        repeat (3) begin
            @(negedge clk);
            if (out_valid || in_credit) begin
                $display("out_valid or in_credit high during reset at %0t", $time);
                errors++;
            end
        end
        @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        if (out_valid || in_credit) begin
            $display("out_valid or in_credit high right after reset at %0t", $time);
            errors++;
        end
        @(posedge clk);
        #1;
        if (errors == start_err) begin
            $display("test 0 reset: pass");
        end else begin
            tests_failed++;
            $display("test 0 reset: FAIL");
        end

        fd = $fopen("hb_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open stimulus file hb_stimulus.txt");
            errors++;
        end else begin
            while ($fscanf(fd, "%s", cmd) == 1) begin
                if (cmd == "#") begin
                    v = $fgets(rest, fd);
                end else if (cmd == "T") begin
                    v = $fscanf(fd, "%d %d %s", id, hold, name);
                    hold_credits = (hold != 0);
                    start_err    = errors;
                    test_outputs = 0;
                    exp_count    = 0;
                end else if (cmd == "E") begin
                    v = $fscanf(fd, "%d", n);
                    repeat (n) begin
                        v = $fscanf(fd, "%d", a);
                        exp_q.push_back(a);
                        care_q.push_back(1'b1);
                    end
                    exp_count += n;
                end else if (cmd == "R" || cmd == "X") begin
                    v = $fscanf(fd, "%d", n);
                    a = 0;
                    if (cmd == "R")
                        v = $fscanf(fd, "%d", a);
                    repeat (n) begin
                        exp_q.push_back(a);
                        care_q.push_back(cmd == "R");
                    end
                    exp_count += n;
                end else if (cmd == "S") begin
                    v = $fscanf(fd, "%d %d", a, n);
                    limit_cycles += 40 * n;
                    repeat (n) send_sample(a);
                end else if (cmd == "P") begin
                    v = $fscanf(fd, "%d %d %d", a, b, n);
                    limit_cycles += 80 * n;
                    if (hold_credits) begin
                        fork
                            send_pairs(a, b, n);
                            release_after_stall();
                        join
                    end else begin
                        send_pairs(a, b, n);
                    end
                end else if (cmd == "N") begin
                    v = $fscanf(fd, "%d", n);
                    idle_window(n);
                end else if (cmd == "D") begin
                    drain_and_check(exp_count);
                    tests_run++;
                    if (errors == start_err) begin
                        $display("test %0d %0s: pass, %0d outputs", id, name, test_outputs);
                    end else begin
                        tests_failed++;
                        $display("test %0d %0s: FAIL", id, name);
                    end
                end else begin
                    $display("unknown command in stimulus file: %0s", cmd);
                    errors++;
                end
            end
            $fclose(fd);
        end

        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hb_decim_top.sv
`timescale 1ns/10ps
`default_nettype none

module hb_decim_top import halfband_pkg::*, flow_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    in_valid,
    input  sample_t in_data,
    output logic    in_credit,
    output logic    out_valid,
    output result_t out_data,
    input  logic    out_credit
);

    logic    in_pop;
    logic    in_empty;
    sample_t fifo_sample;
    logic    out_push;
    logic    out_pop;
    logic    out_empty;
    logic    out_full;
    result_t mac_result;
    tapsum_t pair_sum;

    mac_ctrl_if ctl ();

    credit_fifo #(.payload_t(sample_t), .DEPTH(IN_CREDITS)) u_in_fifo (
        .clk(clk), .reset(reset),
        .push(in_valid), .push_data(in_data),
        .pop(in_pop), .pop_data(fifo_sample),
        .empty(in_empty), .full(),
        .credit(in_credit)
    );

    decim_control u_ctrl (
        .clk(clk), .reset(reset), .ctl(ctl.ctrl),
        .in_empty(in_empty), .in_data(fifo_sample), .in_pop(in_pop),
        .out_full(out_full), .out_empty(out_empty),
        .out_push(out_push), .out_pop(out_pop),
        .out_valid(out_valid), .out_credit(out_credit)
    );

    tap_delay_line u_taps (.clk(clk), .reset(reset), .ctl(ctl.dp), .pair_sum(pair_sum));

    mac_unit u_mac (
        .clk(clk), .reset(reset), .ctl(ctl.dp),
        .pair_sum(pair_sum), .result(mac_result)
    );

    credit_fifo #(.payload_t(result_t), .DEPTH(OUT_DEPTH)) u_out_fifo (
        .clk(clk), .reset(reset),
        .push(out_push), .push_data(mac_result),
        .pop(out_pop), .pop_data(out_data),
        .empty(out_empty), .full(out_full),
        .credit()
    );

endmodule

`default_nettype wire

//--- decim_control.sv
`timescale 1ns/10ps
`default_nettype none

module decim_control import halfband_pkg::*, flow_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    mac_ctrl_if.ctrl  ctl,
    input  logic      in_empty,
    input  sample_t   in_data,
    output logic      in_pop,
    input  logic      out_full,
    input  logic      out_empty,
    output logic      out_push,
    output logic      out_pop,
    output logic      out_valid,
    input  logic      out_credit
);

    ctrl_state_t          state;
    logic                 phase;                 // high when next pop is kept
    logic [TAP_IDX_W-1:0] tap_idx;
    logic [CREDIT_W-1:0]  sink_credits;
    logic                 kept;

    // a result still in flight counts as an occupied slot
    assign in_pop = (state == IDLE) && !in_empty && !out_full && !out_push;
    assign kept   = in_pop && phase;

    assign ctl.shift   = kept;
    assign ctl.clear   = kept;
    assign ctl.sample  = in_data;
    assign ctl.mac_en  = (state == SWEEP);
    assign ctl.tap_idx = tap_idx;
    assign ctl.finish  = (state == FINISH);

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            phase <= 1'b0;                       // first sample is dropped
        else if (in_pop)
            phase <= ~phase;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= IDLE;
            tap_idx  <= '0;
            out_push <= 1'b0;
        end else begin
            out_push <= (state == FINISH);       // result registered by now
            case (state)
                IDLE: begin
                    if (kept) begin
                        state   <= SWEEP;
                        tap_idx <= '0;
                    end
                end
                SWEEP: begin
                    if (tap_idx == TAP_IDX_W'(HALF_TAPS - 1))
                        state <= FINISH;
                    else
                        tap_idx <= tap_idx + 1'b1;
                end
                FINISH:  state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // sink side credits
    assign out_pop   = !out_empty && (sink_credits != '0);
    assign out_valid = out_pop;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sink_credits <= CREDIT_W'(OUT_CREDITS);
        end else begin
            case ({out_valid, out_credit})
                2'b10:   sink_credits <= sink_credits - 1'b1;
                2'b01:   sink_credits <= sink_credits + 1'b1;
                default: sink_credits <= sink_credits;
            endcase
        end
    end

    // a credit comes back only for a result already sent
    a_credit_bound: assert property (@(posedge clk) disable iff (reset)
        out_credit |-> (sink_credits < CREDIT_W'(OUT_CREDITS)))
        else $error("out_credit returned with all sink credits held");

endmodule

`default_nettype wire

//--- mac_unit.sv
`timescale 1ns/10ps
`default_nettype none

module mac_unit import halfband_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    mac_ctrl_if.dp  ctl,
    input  tapsum_t pair_sum,
    output result_t result
);

    acc_t product;
    acc_t acc;
    acc_t rounded;

    // operands widen to 45 bits before the multiply
    assign product = COEFS[ctl.tap_idx] * pair_sum;

    // add half an lsb then drop the fraction bits
    assign rounded = (acc + acc_t'(2 ** (ROUND_SHIFT - 1))) >>> ROUND_SHIFT;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            acc <= '0;
        else if (ctl.clear)
            acc <= '0;
        else if (ctl.mac_en)
            acc <= acc + product;
    end

    always_ff @(posedge clk) begin
        if (ctl.finish)
            result <= rounded[RESULT_W-1:0];     // keep 21 bits
    end

    // the coefficient table has only HALF_TAPS entries
    a_tap_idx_range: assert property (@(posedge clk) disable iff (reset)
        ctl.mac_en |-> (int'(ctl.tap_idx) < HALF_TAPS))
        else $error("tap index out of range during accumulate");

endmodule

`default_nettype wire

//--- tap_delay_line.sv
`timescale 1ns/10ps
`default_nettype none

module tap_delay_line import halfband_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    mac_ctrl_if.dp  ctl,
    output tapsum_t pair_sum
);

    sample_t taps [NUM_TAPS];
    int      hi_idx;

    // mirror tap of the current pair
    assign hi_idx = NUM_TAPS - 1 - int'(ctl.tap_idx);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_TAPS; i++)
                taps[i] <= '0;
        end else if (ctl.shift) begin
            taps[0] <= ctl.sample;
            for (int i = 1; i < NUM_TAPS; i++)
                taps[i] <= taps[i-1];
        end
    end

    // symmetric pre-add, sign extended to 17 bits
    assign pair_sum = tapsum_t'(taps[ctl.tap_idx]) + tapsum_t'(taps[hi_idx]);

endmodule

`default_nettype wire

//--- credit_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module credit_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     full,
    output logic     credit
);

    payload_t                   mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       do_push;
    logic                       do_pop;

    assign empty    = (count == '0);
    assign full     = (int'(count) == DEPTH);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];               // show-ahead read

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            credit <= do_pop;                    // one credit back per pop
            if (do_push)
                wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // partner must hold a credit for every push
    a_no_push_full: assert property (@(posedge clk) disable iff (reset) !(push && full))
        else $error("push into full FIFO, credit rule broken");

endmodule

`default_nettype wire

//--- mac_ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mac_ctrl_if import halfband_pkg::*; ();

    logic                 clear;                 // start of accumulation
    logic                 mac_en;                // accumulate this cycle
    logic [TAP_IDX_W-1:0] tap_idx;               // current pair
    logic                 finish;                // round and register
    logic                 shift;                 // load kept sample
    sample_t              sample;

    modport ctrl (
        output clear, mac_en, tap_idx, finish, shift, sample
    );

    modport dp (
        input clear, mac_en, tap_idx, finish, shift, sample
    );

endinterface

`default_nettype wire

//--- flow_pkg.sv
`default_nettype none

package flow_pkg;

    localparam int IN_CREDITS  = 4;              // input FIFO depth, sender credits at reset
    localparam int OUT_CREDITS = 2;              // sink credits at reset
    localparam int OUT_DEPTH   = 2;
    localparam int CREDIT_W    = $clog2(OUT_CREDITS + 1);

    // sweep controller
    typedef enum logic [1:0] {
        IDLE,
        SWEEP,
        FINISH
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- halfband_pkg.sv
`default_nettype none

package halfband_pkg;

    localparam int SAMPLE_W = 16;                // Q1.15 input
    localparam int COEF_W   = 22;
    localparam int ACC_W    = 45;
    localparam int RESULT_W = 21;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [SAMPLE_W:0]   tapsum_t; // one extra bit for the pair sum
    typedef logic signed [COEF_W-1:0]   coef_t;
    typedef logic signed [ACC_W-1:0]    acc_t;
    typedef logic signed [RESULT_W-1:0] result_t;

    localparam int NUM_TAPS    = 66;
    localparam int HALF_TAPS   = NUM_TAPS / 2;  // symmetric pairs
    localparam int TAP_IDX_W   = 6;
    localparam int ROUND_SHIFT = 20;             // fraction bits dropped at output

    // index k weights taps k and NUM_TAPS-1-k
    localparam coef_t COEFS [0:HALF_TAPS-1] = '{
        22'sd22,      -22'sd38,     22'sd69,       // 0..2
        -22'sd115,    22'sd183,     -22'sd278,     // 3..5
        22'sd408,     -22'sd581,    22'sd808,      // 6..8
        -22'sd1100,   22'sd1470,    -22'sd1934,    // 9..11
        22'sd2507,    -22'sd3208,   22'sd4058,     // 12..14
        -22'sd5081,   22'sd6304,    -22'sd7758,    // 15..17
        22'sd9481,    -22'sd11517,  22'sd13925,    // 18..20
        -22'sd16777,  22'sd20173,   -22'sd24253,   // 21..23
        22'sd29219,   -22'sd35383,  22'sd43246,    // 24..26
        -22'sd53681,  22'sd68336,   -22'sd90759,   // 27..29
        22'sd130184,  -22'sd220505,                // 30..31
        22'sd666872                                // pair nearest the centre
    };

endpackage

`default_nettype wire
